//--- all.f
rtl/axi_rd_pkg.sv
rtl/axi_ar_if.sv
rtl/axi_r_if.sv
rtl/ar_hold_reg.sv
rtl/r_skid_buffer.sv
rtl/axi_rd_register.sv
testbench/tb_axi_rd_register_sva.sv
testbench/tb_axi_rd_register.sv

//--- rtl/ar_hold_reg.sv
// ~~~~~~~~~~~~~~~~~~~~
// ar hold register
// one-entry request register with registered
// ready, one bubble cycle per request
// ~~~~~~~~~~~~~~~~~~~~

module ar_hold_reg import axi_rd_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   axi_ar_if.snk    up,
   axi_ar_if.src    down
);

   ar_beat_t beat_q;
   logic     valid_q;
   logic     valid_next;
   logic     ready_q;
   logic     load;

   assign down.beat  = beat_q;
   assign down.valid = valid_q;
   assign up.ready   = ready_q;

   always_comb begin
      valid_next = valid_q;
      load       = 1'b0;
      if (ready_q) begin
         // register is empty here, take whatever is offered
         valid_next = up.valid;
         load       = up.valid;
      end else if (down.ready) begin
         valid_next = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= 1'b0;
         ready_q <= 1'b0;
      end else begin
         valid_q <= valid_next;
         // accept only when the register is empty next cycle
         ready_q <= ~valid_next;
      end
   end

   // request payload
   always_ff @(posedge clk) begin
      if (load) begin
         beat_q <= up.beat;
      end
   end

endmodule

//--- rtl/axi_ar_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// axi read address channel
// request beat with valid/ready handshake
// ~~~~~~~~~~~~~~~~~~~~

interface axi_ar_if import axi_rd_pkg::*; ();

   ar_beat_t beat;
   logic     valid;
   logic     ready;

   // source drives the request, sink answers with ready
   modport src (
      output beat,
      output valid,
      input  ready
   );

   modport snk (
      input  beat,
      input  valid,
      output ready
   );

endinterface

//--- rtl/axi_r_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// axi read data channel
// data beat with valid/ready handshake
// ~~~~~~~~~~~~~~~~~~~~

interface axi_r_if import axi_rd_pkg::*; ();

   r_beat_t beat;
   logic    valid;
   logic    ready;

   // source drives the data beat, sink answers with ready
   modport src (
      output beat,
      output valid,
      input  ready
   );

   modport snk (
      input  beat,
      input  valid,
      output ready
   );

endinterface

//--- rtl/axi_rd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// axi read slice package
// field widths, encodings and beat structs
// shared by the read-channel register slice
// ~~~~~~~~~~~~~~~~~~~~

package axi_rd_pkg;

   localparam int ID_WIDTH   = 8;
   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 32;
   localparam int LEN_WIDTH  = 8;
   localparam int SIZE_WIDTH = 3;
   localparam int PROT_WIDTH = 3;

   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10,
      BURST_RSVD  = 2'b11
   } axi_burst_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } axi_resp_e;

   // one read request, 56 bits
   typedef struct packed {
      logic [ID_WIDTH-1:0]   id;
      logic [ADDR_WIDTH-1:0] addr;
      logic [LEN_WIDTH-1:0]  len;
      logic [SIZE_WIDTH-1:0] size;
      axi_burst_e            burst;
      logic [PROT_WIDTH-1:0] prot;
   } ar_beat_t;

   // one read data beat, 43 bits
   typedef struct packed {
      logic [ID_WIDTH-1:0]   id;
      logic [DATA_WIDTH-1:0] data;
      axi_resp_e             resp;
      logic                  last;
   } r_beat_t;

   // skid buffer occupancy
   typedef enum logic [1:0] {
      SKID_EMPTY = 2'd0,
      SKID_ONE   = 2'd1,
      SKID_TWO   = 2'd2
   } r_skid_state_e;

endpackage

//--- rtl/axi_rd_register.sv
// ~~~~~~~~~~~~~~~~~~~~
// axi read register slice
// registers the AR and R channels between a
// subordinate port and a manager port
// ~~~~~~~~~~~~~~~~~~~~

module axi_rd_register import axi_rd_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,

   // subordinate side, read address
   input  logic [ID_WIDTH-1:0]   s_axi_arid,
   input  logic [ADDR_WIDTH-1:0] s_axi_araddr,
   input  logic [LEN_WIDTH-1:0]  s_axi_arlen,
   input  logic [SIZE_WIDTH-1:0] s_axi_arsize,
   input  axi_burst_e            s_axi_arburst,
   input  logic [PROT_WIDTH-1:0] s_axi_arprot,
   input  logic                  s_axi_arvalid,
   output logic                  s_axi_arready,

   // subordinate side, read data
   output logic [ID_WIDTH-1:0]   s_axi_rid,
   output logic [DATA_WIDTH-1:0] s_axi_rdata,
   output axi_resp_e             s_axi_rresp,
   output logic                  s_axi_rlast,
   output logic                  s_axi_rvalid,
   input  logic                  s_axi_rready,

   // manager side, read address
   output logic [ID_WIDTH-1:0]   m_axi_arid,
   output logic [ADDR_WIDTH-1:0] m_axi_araddr,
   output logic [LEN_WIDTH-1:0]  m_axi_arlen,
   output logic [SIZE_WIDTH-1:0] m_axi_arsize,
   output axi_burst_e            m_axi_arburst,
   output logic [PROT_WIDTH-1:0] m_axi_arprot,
   output logic                  m_axi_arvalid,
   input  logic                  m_axi_arready,

   // manager side, read data
   input  logic [ID_WIDTH-1:0]   m_axi_rid,
   input  logic [DATA_WIDTH-1:0] m_axi_rdata,
   input  axi_resp_e             m_axi_rresp,
   input  logic                  m_axi_rlast,
   input  logic                  m_axi_rvalid,
   output logic                  m_axi_rready
);

   axi_ar_if s_ar ();
   axi_ar_if m_ar ();
   axi_r_if  m_r ();
   axi_r_if  s_r ();

   // incoming requests
   assign s_ar.beat = '{
      id:    s_axi_arid,
      addr:  s_axi_araddr,
      len:   s_axi_arlen,
      size:  s_axi_arsize,
      burst: s_axi_arburst,
      prot:  s_axi_arprot
   };
   assign s_ar.valid    = s_axi_arvalid;
   assign s_axi_arready = s_ar.ready;

   // outgoing requests
   assign m_axi_arid    = m_ar.beat.id;
   assign m_axi_araddr  = m_ar.beat.addr;
   assign m_axi_arlen   = m_ar.beat.len;
   assign m_axi_arsize  = m_ar.beat.size;
   assign m_axi_arburst = m_ar.beat.burst;
   assign m_axi_arprot  = m_ar.beat.prot;
   assign m_axi_arvalid = m_ar.valid;
   assign m_ar.ready    = m_axi_arready;

   // read data from the manager port
   assign m_r.beat = '{
      id:   m_axi_rid,
      data: m_axi_rdata,
      resp: m_axi_rresp,
      last: m_axi_rlast
   };
   assign m_r.valid    = m_axi_rvalid;
   assign m_axi_rready = m_r.ready;

   // read data back to the subordinate port
   assign s_axi_rid    = s_r.beat.id;
   assign s_axi_rdata  = s_r.beat.data;
   assign s_axi_rresp  = s_r.beat.resp;
   assign s_axi_rlast  = s_r.beat.last;
   assign s_axi_rvalid = s_r.valid;
   assign s_r.ready    = s_axi_rready;

   // AR: simple register, one request in flight
   ar_hold_reg u_ar_reg (
      .clk  (clk),
      .rst  (rst),
      .up   (s_ar),
      .down (m_ar)
   );

   // R: skid buffer, full throughput
   r_skid_buffer u_r_skid (
      .clk  (clk),
      .rst  (rst),
      .up   (m_r),
      .down (s_r)
   );

endmodule

//--- rtl/r_skid_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~
// r skid buffer
// two-entry read data buffer, registered
// ready, one beat per cycle
// ~~~~~~~~~~~~~~~~~~~~

module r_skid_buffer import axi_rd_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   axi_r_if.snk     up,
   axi_r_if.src     down
);

   r_skid_state_e state;
   r_skid_state_e state_next;

   r_beat_t out_beat;
   r_beat_t skid_beat;

   logic ready_q;
   logic ready_next;
   logic out_valid;
   logic skid_valid;
   logic load_out;
   logic load_skid;
   logic move_skid;

   assign out_valid  = (state != SKID_EMPTY);
   assign skid_valid = (state == SKID_TWO);

   assign down.beat  = out_beat;
   assign down.valid = out_valid;
   assign up.ready   = ready_q;

   // ready next cycle if downstream takes a beat now, or the
   // skid entry cannot be filled at this edge
   assign ready_next = down.ready | (~skid_valid & (~out_valid | ~up.valid));

   always_comb begin
      state_next = state;
      load_out   = 1'b0;
      load_skid  = 1'b0;
      move_skid  = 1'b0;
      if (ready_q) begin
         // skid entry is always empty while ready is high
         if (down.ready || state == SKID_EMPTY) begin
            load_out   = up.valid;
            state_next = up.valid ? SKID_ONE : SKID_EMPTY;
         end else begin
            // output stalled, park the new beat
            load_skid  = up.valid;
            state_next = up.valid ? SKID_TWO : SKID_ONE;
         end
      end else if (down.ready) begin
         // upstream blocked, drain skid into output
         move_skid = skid_valid;
         case (state)
            SKID_TWO: state_next = SKID_ONE;
            default:  state_next = SKID_EMPTY;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= SKID_EMPTY;
         ready_q <= 1'b0;
      end else begin
         state   <= state_next;
         ready_q <= ready_next;
      end
   end

   // output and skid payload
   always_ff @(posedge clk) begin
      if (load_out) begin
         out_beat <= up.beat;
      end else if (move_skid) begin
         out_beat <= skid_beat;
      end

      if (load_skid) begin
         skid_beat <= up.beat;
      end
   end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the axi read slice testbench with verilator

set -u
cd "$(dirname "$0")" || exit 1

top=tb_axi_rd_register
build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module "$top" --Mdir "$build_dir" -f all.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

"./$build_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" "$log"; then
   echo "failures reported in $log"
   exit 1
fi

echo "simulation finished without failures"
exit 0

//--- testbench/tb_axi_rd_register.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the axi read register slice
// random AR and R traffic against reference
// queues, reset state and full-rate burst
// ~~~~~~~~~~~~~~~~~~~~

module tb_axi_rd_register import axi_rd_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 16;
   localparam int RUN_LEN      = 2000;
   localparam int BURST_CYCLES = 64;
   localparam int TIMEOUT_NS   =
      (RUN_LEN * 4 + RESET_CYCLES + BURST_CYCLES + 100) * CLK_PERIOD;

   logic                  clk = 1'b0;
   logic                  rst;
   logic [ID_WIDTH-1:0]   s_axi_arid;
   logic [ADDR_WIDTH-1:0] s_axi_araddr;
   logic [LEN_WIDTH-1:0]  s_axi_arlen;
   logic [SIZE_WIDTH-1:0] s_axi_arsize;
   axi_burst_e            s_axi_arburst;
   logic [PROT_WIDTH-1:0] s_axi_arprot;
   logic                  s_axi_arvalid;
   logic                  s_axi_arready;
   logic [ID_WIDTH-1:0]   s_axi_rid;
   logic [DATA_WIDTH-1:0] s_axi_rdata;
   axi_resp_e             s_axi_rresp;
   logic                  s_axi_rlast;
   logic                  s_axi_rvalid;
   logic                  s_axi_rready;
   logic [ID_WIDTH-1:0]   m_axi_arid;
   logic [ADDR_WIDTH-1:0] m_axi_araddr;
   logic [LEN_WIDTH-1:0]  m_axi_arlen;
   logic [SIZE_WIDTH-1:0] m_axi_arsize;
   axi_burst_e            m_axi_arburst;
   logic [PROT_WIDTH-1:0] m_axi_arprot;
   logic                  m_axi_arvalid;
   logic                  m_axi_arready;
   logic [ID_WIDTH-1:0]   m_axi_rid;
   logic [DATA_WIDTH-1:0] m_axi_rdata;
   axi_resp_e             m_axi_rresp;
   logic                  m_axi_rlast;
   logic                  m_axi_rvalid;
   logic                  m_axi_rready;

   // reference queues, filled on the input side
   ar_beat_t ar_expect[$];
   r_beat_t  r_expect[$];

   int   seed        = 32'h684f;
   int   ar_in       = 0;
   int   ar_out      = 0;
   int   r_in        = 0;
   int   r_out       = 0;
   int   ar_errors   = 0;
   int   r_errors    = 0;
   int   ctrl_errors = 0;
   int   end_errors  = 0;
   int   since_reset = 0;
   int   burst_cyc   = 0;
   logic ar_fire     = 1'b0;
   logic r_fire      = 1'b0;
   logic burst_on    = 1'b0;

   axi_rd_register u_dut (.*);

   initial begin
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] random_word();
      return $random(seed);
   endfunction

   function automatic logic chance(input int pct);
      return (random_word() % 32'd100) < pct;
   endfunction

   task automatic check_ar_beat(input string name, input ar_beat_t exp,
                                input ar_beat_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         ar_errors++;
      end
   endtask

   task automatic check_r_beat(input string name, input r_beat_t exp,
                               input r_beat_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         r_errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         ctrl_errors++;
      end
   endtask

   task automatic check_idle_outputs();
      check_flag("s_axi_arready", 1'b0, s_axi_arready);
      check_flag("m_axi_arvalid", 1'b0, m_axi_arvalid);
      check_flag("m_axi_rready", 1'b0, m_axi_rready);
      check_flag("s_axi_rvalid", 1'b0, s_axi_rvalid);
   endtask

   // new request only once the previous one has been taken
   task automatic drive_ar_source(input logic enable);
      logic [31:0] w;
      if (!s_axi_arvalid || ar_fire) begin
         if (enable && chance(75)) begin
            w = random_word();
            s_axi_arid    = w[ID_WIDTH-1:0];
            s_axi_araddr  = random_word();
            w = random_word();
            s_axi_arlen   = w[LEN_WIDTH-1:0];
            s_axi_arsize  = w[8+:SIZE_WIDTH];
            s_axi_arburst = axi_burst_e'(w[12+:2]);
            s_axi_arprot  = w[16+:PROT_WIDTH];
            s_axi_arvalid = 1'b1;
         end else begin
            s_axi_arvalid = 1'b0;
         end
      end
   endtask

   task automatic drive_r_source(input logic enable, input int pct);
      logic [31:0] w;
      if (!m_axi_rvalid || r_fire) begin
         if (enable && chance(pct)) begin
            w = random_word();
            m_axi_rid    = w[ID_WIDTH-1:0];
            m_axi_rresp  = axi_resp_e'(w[8+:2]);
            m_axi_rlast  = w[10];
            m_axi_rdata  = random_word();
            m_axi_rvalid = 1'b1;
         end else begin
            m_axi_rvalid = 1'b0;
         end
      end
   endtask

   // outputs are checked before the new inputs are queued
   task automatic sample_transfers();
      ar_beat_t ar_beat;
      r_beat_t  r_beat;
      ar_fire = s_axi_arvalid && s_axi_arready;
      r_fire  = m_axi_rvalid && m_axi_rready;
      if (m_axi_arvalid && m_axi_arready) begin
         ar_beat = '{id: m_axi_arid, addr: m_axi_araddr, len: m_axi_arlen,
                     size: m_axi_arsize, burst: m_axi_arburst, prot: m_axi_arprot};
         if (ar_expect.size() == 0) begin
            $display("request left m_axi_ar although none was accepted");
            ar_errors++;
         end else begin
            check_ar_beat("m_axi_ar", ar_expect.pop_front(), ar_beat);
         end
         ar_out++;
      end
      if (s_axi_rvalid && s_axi_rready) begin
         r_beat = '{id: s_axi_rid, data: s_axi_rdata, resp: s_axi_rresp,
                    last: s_axi_rlast};
         if (r_expect.size() == 0) begin
            $display("beat left s_axi_r although none was accepted");
            r_errors++;
         end else begin
            check_r_beat("s_axi_r", r_expect.pop_front(), r_beat);
         end
         r_out++;
      end
      if (ar_fire) begin
         ar_beat = '{id: s_axi_arid, addr: s_axi_araddr, len: s_axi_arlen,
                     size: s_axi_arsize, burst: s_axi_arburst, prot: s_axi_arprot};
         ar_expect.push_back(ar_beat);
         ar_in++;
      end
      if (r_fire) begin
         r_beat = '{id: m_axi_rid, data: m_axi_rdata, resp: m_axi_rresp,
                    last: m_axi_rlast};
         r_expect.push_back(r_beat);
         r_in++;
      end
   endtask

   // mid-cycle sampling, inputs and outputs are settled here
   always @(negedge clk) begin
      if (rst) begin
         since_reset = 0;
         check_idle_outputs();
      end else begin
         since_reset++;
         if (since_reset == 1) begin
            check_idle_outputs();
         end else begin
            if (since_reset == 2) begin
               check_flag("s_axi_arready", 1'b1, s_axi_arready);
               check_flag("m_axi_rready", 1'b1, m_axi_rready);
            end
            check_flag("s_axi_arready", ~m_axi_arvalid, s_axi_arready);
         end
         if (burst_on) begin
            if (burst_cyc >= 1) begin
               check_flag("s_axi_rvalid", 1'b1, s_axi_rvalid);
            end
            burst_cyc++;
         end else begin
            burst_cyc = 0;
         end
         sample_transfers();
      end
   end

   initial begin
      rst           = 1'b1;
      s_axi_arid    = '0;
      s_axi_araddr  = '0;
      s_axi_arlen   = '0;
      s_axi_arsize  = '0;
      s_axi_arburst = BURST_FIXED;
      s_axi_arprot  = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      m_axi_arready = 1'b0;
      m_axi_rid     = '0;
      m_axi_rdata   = '0;
      m_axi_rresp   = RESP_OKAY;
      m_axi_rlast   = 1'b0;
      m_axi_rvalid  = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;

      // random traffic and random back-pressure on both channels
      while (ar_out < RUN_LEN || r_out < RUN_LEN) begin
         @(posedge clk);
         #1;
         drive_ar_source(ar_in < RUN_LEN);
         drive_r_source(r_in < RUN_LEN, 75);
         m_axi_arready = chance(70);
         s_axi_rready  = chance(70);
      end

      // full-rate burst, one beat per cycle expected
      @(posedge clk);
      #1;
      s_axi_rready = 1'b1;
      burst_on     = 1'b1;
      drive_r_source(1'b1, 100);
      repeat (BURST_CYCLES - 1) begin
         @(posedge clk);
         #1;
         drive_r_source(1'b1, 100);
      end
      @(posedge clk);
      #1;
      burst_on = 1'b0;
      drive_r_source(1'b0, 0);

      while (ar_out != ar_in || r_out != r_in) @(posedge clk);
      repeat (4) @(posedge clk);

      if (ar_expect.size() != 0 || r_expect.size() != 0) begin
         $display("reference queues not empty at the end: %0d requests, %0d beats",
                  ar_expect.size(), r_expect.size());
         end_errors++;
      end
      if (ar_in != RUN_LEN || r_in < RUN_LEN + BURST_CYCLES) begin
         $display("too few transfers accepted: %0d requests, %0d beats", ar_in, r_in);
         end_errors++;
      end
      $display("errors: ar %0d, r %0d, control %0d, end %0d, assertion %0d",
               ar_errors, r_errors, ctrl_errors, end_errors,
               u_dut.u_sva.fail_count);
      if (ar_errors + r_errors + ctrl_errors + end_errors +
          u_dut.u_sva.fail_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("timeout: traffic did not complete within %0d ns", TIMEOUT_NS);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- testbench/tb_axi_rd_register_sva.sv
// ~~~~~~~~~~~~~~~~~~~~
// read slice assertions
// handshake stability and reset state
// ~~~~~~~~~~~~~~~~~~~~

module tb_axi_rd_register_sva import axi_rd_pkg::*; (
   input logic                  clk,
   input logic                  rst,
   input logic [ID_WIDTH-1:0]   m_axi_arid,
   input logic [ADDR_WIDTH-1:0] m_axi_araddr,
   input logic [LEN_WIDTH-1:0]  m_axi_arlen,
   input logic [SIZE_WIDTH-1:0] m_axi_arsize,
   input axi_burst_e            m_axi_arburst,
   input logic [PROT_WIDTH-1:0] m_axi_arprot,
   input logic                  m_axi_arvalid,
   input logic                  m_axi_arready,
   input logic [ID_WIDTH-1:0]   s_axi_rid,
   input logic [DATA_WIDTH-1:0] s_axi_rdata,
   input axi_resp_e             s_axi_rresp,
   input logic                  s_axi_rlast,
   input logic                  s_axi_rvalid,
   input logic                  s_axi_rready,
   input logic                  s_axi_arready,
   input logic                  m_axi_rready
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;

   // stalled request holds until the manager takes it
   ar_hold: assert property (@(posedge clk) disable iff (rst)
      m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable({m_axi_arid,
      m_axi_araddr, m_axi_arlen, m_axi_arsize, m_axi_arburst, m_axi_arprot}))
      else begin
         $error("m_axi_ar valid or payload changed before the handshake");
         fail_count++;
      end

   r_hold: assert property (@(posedge clk) disable iff (rst)
      s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid &&
      $stable({s_axi_rid, s_axi_rdata, s_axi_rresp, s_axi_rlast}))
      else begin
         $error("s_axi_r valid or payload changed before the handshake");
         fail_count++;
      end

   // outputs one edge after a reset cycle
   reset_idle: assert property (@(posedge clk)
      $past(rst) |-> !s_axi_arready && !m_axi_arvalid && !m_axi_rready && !s_axi_rvalid)
      else begin
         $error("control outputs not idle while in reset");
         fail_count++;
      end

endmodule

bind axi_rd_register tb_axi_rd_register_sva u_sva (.*);
